// File: ppu_system.f
rtl/ppu_pkg.sv
rtl/vram_pkg.sv
rtl/vram_bus_if.sv
rtl/ppu_regs.sv
rtl/ppu_timing.sv
rtl/tile_fetch.sv
rtl/vram_arbiter.sv
rtl/ppu_system.sv
sim/ppu_system_chk.sv
sim/tb_ppu_system.sv

// File: rtl/ppu_pkg.sv
/* PPU register window constants
   select codes, raster geometry, vblank lines and control/mask bit positions */
`default_nettype none

package ppu_pkg;

    // cpu register select codes
    localparam logic [2:0] RS_PPUCTRL   = 3'd0;
    localparam logic [2:0] RS_PPUMASK   = 3'd1;
    localparam logic [2:0] RS_PPUSTATUS = 3'd2;
    localparam logic [2:0] RS_OAMADDR   = 3'd3;
    localparam logic [2:0] RS_OAMDATA   = 3'd4;
    localparam logic [2:0] RS_PPUSCROLL = 3'd5;
    localparam logic [2:0] RS_PPUADDR   = 3'd6;
    localparam logic [2:0] RS_PPUDATA   = 3'd7;

    // full raster and its visible part
    localparam logic [8:0] SCREEN_WIDTH   = 9'd341;
    localparam logic [8:0] SCREEN_HEIGHT  = 9'd262;
    localparam logic [8:0] VISIBLE_WIDTH  = 9'd256;
    localparam logic [8:0] VISIBLE_HEIGHT = 9'd240;

    // vblank flag is set and cleared at x=0 of these lines
    localparam logic [8:0] VBLANK_START_LINE = 9'd241;
    localparam logic [8:0] VBLANK_END_LINE   = 9'd261;

    // bit positions in PPUCTRL and PPUMASK
    localparam int CTRL_NMI_BIT   = 7;
    localparam int CTRL_INC32_BIT = 2;
    localparam int MASK_BG_BIT    = 3;

    // i_rw level for a cpu read
    localparam logic RW_READ = 1'b1;

    // raster position to pixel output, in cycles
    localparam int FETCH_LATENCY = 3;

endpackage

`default_nettype wire

// File: rtl/ppu_regs.sv
/* PPU cpu register window
   scroll/address registers, palette, OAM, ppudata bus requests and the vblank interrupt */
`timescale 1ns/10ps
`default_nettype none

module ppu_regs (
    input  wire                  i_clk,
    input  wire                  i_reset_n,
    input  wire                  i_cs_n,
    input  wire                  i_rw,
    input  wire  [2:0]           i_rs,
    input  wire  [7:0]           i_data,
    input  wire                  i_vblank_set,
    input  wire                  i_vblank_clear,
    input  wire  [1:0]           i_colour_sel,
    output logic [7:0]           o_data,
    output logic                 o_int_n,
    output logic [1:0]           o_nametable_sel,
    output logic                 o_bg_enable,
    output logic [5:0]           o_pixel_colour,
    vram_bus_if.requester        bus
);

    logic [7:0]  ctrl_r;
    logic [7:0]  mask_r;
    logic [7:0]  oam_addr_r;
    logic [14:0] t_r;
    logic [14:0] v_r;
    logic        w_r;
    logic        vblank_r;
    logic [7:0]  read_buf_r;

    logic [7:0]  palette [32];
    logic [7:0]  oam [256];

    logic                         req_r;
    logic                         we_r;
    logic [vram_pkg::VADDR_W-1:0] addr_r;
    logic [vram_pkg::VDATA_W-1:0] wdata_r;

    logic        cpu_rd;
    logic        cpu_wr;
    logic        in_palette;
    logic [14:0] v_step;

    assign cpu_rd     = !i_cs_n && (i_rw == ppu_pkg::RW_READ);
    assign cpu_wr     = !i_cs_n && (i_rw != ppu_pkg::RW_READ);
    assign in_palette = {2'b00, v_r[13:0]} >= vram_pkg::PALETTE_BASE;
    assign v_step     = ctrl_r[ppu_pkg::CTRL_INC32_BIT] ? 15'd32 : 15'd1;

    // register writes, the shared toggle and vram address stepping
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ctrl_r     <= '0;
            mask_r     <= '0;
            oam_addr_r <= '0;
            t_r        <= '0;
            v_r        <= '0;
            w_r        <= 1'b0;
        end
        else if (cpu_wr)
        begin
            case (i_rs)
                ppu_pkg::RS_PPUCTRL:
                begin
                    ctrl_r     <= i_data;
                    t_r[11:10] <= i_data[1:0];
                end
                ppu_pkg::RS_PPUMASK:
                begin
                    mask_r <= i_data;
                end
                ppu_pkg::RS_OAMADDR:
                begin
                    oam_addr_r <= i_data;
                end
                ppu_pkg::RS_OAMDATA:
                begin
                    oam_addr_r <= oam_addr_r + 8'd1;
                end
                ppu_pkg::RS_PPUSCROLL:
                begin
                    w_r <= !w_r;
                    if (!w_r)
                    begin
                        // coarse x
                        t_r[4:0] <= i_data[7:3];
                    end
                    else
                    begin
                        // coarse y and fine y
                        t_r[9:5]   <= i_data[7:3];
                        t_r[14:12] <= i_data[2:0];
                    end
                end
                ppu_pkg::RS_PPUADDR:
                begin
                    w_r <= !w_r;
                    if (!w_r)
                    begin
                        t_r[13:8] <= i_data[5:0];
                        t_r[14]   <= 1'b0;
                    end
                    else
                    begin
                        // second write copies the completed t into v
                        t_r[7:0] <= i_data;
                        v_r      <= {t_r[14:8], i_data};
                    end
                end
                ppu_pkg::RS_PPUDATA:
                begin
                    v_r <= v_r + v_step;
                end
                default:
                begin
                end
            endcase
        end
        else if (cpu_rd)
        begin
            if (i_rs == ppu_pkg::RS_PPUSTATUS)
            begin
                w_r <= 1'b0;
            end
            else if (i_rs == ppu_pkg::RS_PPUDATA)
            begin
                v_r <= v_r + v_step;
            end
        end
    end

    // OAM and palette storage
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                palette[i] <= '0;
            end
            for (int i = 0; i < 256; i++)
            begin
                oam[i] <= '0;
            end
        end
        else
        begin
            if (cpu_wr && (i_rs == ppu_pkg::RS_OAMDATA))
            begin
                oam[oam_addr_r] <= i_data;
            end
            if (cpu_wr && (i_rs == ppu_pkg::RS_PPUDATA) && in_palette)
            begin
                palette[v_r[4:0]] <= i_data;
            end
        end
    end

    // ppudata outside the palette goes out as a one-cycle bus request
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            req_r <= 1'b0;
        end
        else
        begin
            req_r <= !i_cs_n && (i_rs == ppu_pkg::RS_PPUDATA) && !in_palette;
        end
    end

    always_ff @(posedge i_clk)
    begin
        we_r    <= cpu_wr;
        addr_r  <= v_r[13:0];
        wdata_r <= i_data;
    end

    assign bus.req   = req_r;
    assign bus.we    = we_r;
    assign bus.addr  = addr_r;
    assign bus.wdata = wdata_r;

    // read buffer fills when the arbiter returns our read
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            read_buf_r <= '0;
        end
        else if (bus.rvalid)
        begin
            read_buf_r <= bus.rdata;
        end
    end

    // a status read wins over the line strobes
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            vblank_r <= 1'b0;
        end
        else if (cpu_rd && (i_rs == ppu_pkg::RS_PPUSTATUS))
        begin
            vblank_r <= 1'b0;
        end
        else if (i_vblank_set)
        begin
            vblank_r <= 1'b1;
        end
        else if (i_vblank_clear)
        begin
            vblank_r <= 1'b0;
        end
    end

    always_comb
    begin
        o_data = 8'h00;
        if (cpu_rd)
        begin
            case (i_rs)
                ppu_pkg::RS_PPUSTATUS:
                begin
                    o_data = {vblank_r, 7'b0000000};
                end
                ppu_pkg::RS_OAMDATA:
                begin
                    o_data = oam[oam_addr_r];
                end
                ppu_pkg::RS_PPUDATA:
                begin
                    // palette answers directly, vram answers with the buffered byte
                    o_data = in_palette ? palette[v_r[4:0]] : read_buf_r;
                end
                default:
                begin
                    o_data = 8'h00;
                end
            endcase
        end
    end

    assign o_int_n         = !(vblank_r && ctrl_r[ppu_pkg::CTRL_NMI_BIT]);
    assign o_nametable_sel = ctrl_r[1:0];
    assign o_bg_enable     = mask_r[ppu_pkg::MASK_BG_BIT];
    assign o_pixel_colour  = palette[{3'b000, i_colour_sel}][5:0];

endmodule

`default_nettype wire

// File: rtl/ppu_system.sv
/* reduced PPU top level
   cpu register window, raster timing and background fetch on one shared video bus */
`timescale 1ns/10ps
`default_nettype none

module ppu_system (
    input  wire         i_clk,
    input  wire         i_reset_n,

    // cpu side
    input  wire         i_cs_n,
    input  wire         i_rw,
    input  wire  [2:0]  i_rs,
    input  wire  [7:0]  i_data,
    output logic [7:0]  o_data,
    output logic        o_int_n,

    // external video bus
    output logic        o_video_rd_n,
    output logic        o_video_we_n,
    output logic [13:0] o_video_address,
    output logic [7:0]  o_video_data,
    input  wire  [7:0]  i_video_data,

    // pixel output
    output logic [8:0]  o_video_x,
    output logic [8:0]  o_video_y,
    output logic        o_video_visible,
    output logic [5:0]  o_video_colour
);

    logic [8:0] raster_x;
    logic [8:0] raster_y;
    logic       raster_visible;
    logic       vblank_set;
    logic       vblank_clear;
    logic [1:0] nametable_sel;
    logic       bg_enable;
    logic [1:0] colour_sel;

    vram_bus_if fetch_bus ();
    vram_bus_if cpu_bus ();

    ppu_regs regs_i (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cs_n          (i_cs_n),
        .i_rw            (i_rw),
        .i_rs            (i_rs),
        .i_data          (i_data),
        .i_vblank_set    (vblank_set),
        .i_vblank_clear  (vblank_clear),
        .i_colour_sel    (colour_sel),
        .o_data          (o_data),
        .o_int_n         (o_int_n),
        .o_nametable_sel (nametable_sel),
        .o_bg_enable     (bg_enable),
        .o_pixel_colour  (o_video_colour),
        .bus             (cpu_bus)
    );

    ppu_timing timing_i (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .o_raster_x       (raster_x),
        .o_raster_y       (raster_y),
        .o_raster_visible (raster_visible),
        .o_vblank_set     (vblank_set),
        .o_vblank_clear   (vblank_clear)
    );

    tile_fetch fetch_i (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .i_raster_x       (raster_x),
        .i_raster_y       (raster_y),
        .i_raster_visible (raster_visible),
        .i_nametable_sel  (nametable_sel),
        .i_bg_enable      (bg_enable),
        .o_colour_sel     (colour_sel),
        .o_video_x        (o_video_x),
        .o_video_y        (o_video_y),
        .o_video_visible  (o_video_visible),
        .bus              (fetch_bus)
    );

    vram_arbiter arb_i (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_video_data    (i_video_data),
        .fetch_bus       (fetch_bus),
        .cpu_bus         (cpu_bus),
        .o_video_rd_n    (o_video_rd_n),
        .o_video_we_n    (o_video_we_n),
        .o_video_address (o_video_address),
        .o_video_data    (o_video_data)
    );

endmodule

`default_nettype wire

// File: rtl/ppu_timing.sv
/* raster counters over the full 341 x 262 frame
   with the visible flag and the vblank line strobes */
`timescale 1ns/10ps
`default_nettype none

module ppu_timing (
    input  wire        i_clk,
    input  wire        i_reset_n,
    output logic [8:0] o_raster_x,
    output logic [8:0] o_raster_y,
    output logic       o_raster_visible,
    output logic       o_vblank_set,
    output logic       o_vblank_clear
);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_raster_x <= '0;
            o_raster_y <= '0;
        end
        else if (o_raster_x == ppu_pkg::SCREEN_WIDTH - 9'd1)
        begin
            o_raster_x <= '0;
            if (o_raster_y == ppu_pkg::SCREEN_HEIGHT - 9'd1)
            begin
                o_raster_y <= '0;
            end
            else
            begin
                o_raster_y <= o_raster_y + 9'd1;
            end
        end
        else
        begin
            o_raster_x <= o_raster_x + 9'd1;
        end
    end

    assign o_raster_visible = (o_raster_x < ppu_pkg::VISIBLE_WIDTH) &&
                              (o_raster_y < ppu_pkg::VISIBLE_HEIGHT);

    // strobes last the single x=0 cycle of their line
    assign o_vblank_set   = (o_raster_x == 9'd0) && (o_raster_y == ppu_pkg::VBLANK_START_LINE);
    assign o_vblank_clear = (o_raster_x == 9'd0) && (o_raster_y == ppu_pkg::VBLANK_END_LINE);

endmodule

`default_nettype wire

// File: rtl/tile_fetch.sv
/* background tile fetcher
   reads one nametable byte per 8-pixel column and aligns it with the delayed raster */
`timescale 1ns/10ps
`default_nettype none

module tile_fetch (
    input  wire        i_clk,
    input  wire        i_reset_n,
    input  wire  [8:0] i_raster_x,
    input  wire  [8:0] i_raster_y,
    input  wire        i_raster_visible,
    input  wire  [1:0] i_nametable_sel,
    input  wire        i_bg_enable,
    output logic [1:0] o_colour_sel,
    output logic [8:0] o_video_x,
    output logic [8:0] o_video_y,
    output logic       o_video_visible,
    vram_bus_if.requester bus
);

    logic [8:0] x_pipe [ppu_pkg::FETCH_LATENCY];
    logic [8:0] y_pipe [ppu_pkg::FETCH_LATENCY];
    logic [ppu_pkg::FETCH_LATENCY-1:0] vis_pipe;

    logic                         req_r;
    logic [vram_pkg::VADDR_W-1:0] addr_r;
    logic [vram_pkg::VDATA_W-1:0] tile_r;
    logic                         tile_edge;

    assign tile_edge = i_raster_visible && (i_raster_x[2:0] == 3'd0);

    // nametable byte for the column starting at this x
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            req_r <= 1'b0;
        end
        else
        begin
            req_r <= tile_edge;
        end
    end

    always_ff @(posedge i_clk)
    begin
        addr_r <= vram_pkg::NAMETABLE_BASE +
                  {2'b00, i_nametable_sel, i_raster_y[7:3], i_raster_x[7:3]};
    end

    assign bus.req   = req_r;
    assign bus.we    = 1'b0;
    assign bus.addr  = addr_r;
    assign bus.wdata = '0;

    // data arrives two cycles after the boundary and covers the next 8 pixels
    always_ff @(posedge i_clk)
    begin
        if (bus.rvalid)
        begin
            tile_r <= bus.rdata;
        end
    end

    // coordinates trail the raster by the fetch latency
    always_ff @(posedge i_clk)
    begin
        x_pipe[0] <= i_raster_x;
        y_pipe[0] <= i_raster_y;
        for (int i = 1; i < ppu_pkg::FETCH_LATENCY; i++)
        begin
            x_pipe[i] <= x_pipe[i-1];
            y_pipe[i] <= y_pipe[i-1];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            vis_pipe <= '0;
        end
        else
        begin
            vis_pipe <= {vis_pipe[ppu_pkg::FETCH_LATENCY-2:0], i_raster_visible};
        end
    end

    assign o_video_x       = x_pipe[ppu_pkg::FETCH_LATENCY-1];
    assign o_video_y       = y_pipe[ppu_pkg::FETCH_LATENCY-1];
    assign o_video_visible = vis_pipe[ppu_pkg::FETCH_LATENCY-1];

    // entry 0 when blanked or background off
    assign o_colour_sel = (o_video_visible && i_bg_enable) ? tile_r[1:0] : 2'b00;

endmodule

`default_nettype wire

// File: rtl/vram_arbiter.sv
/* video bus arbiter
   fetcher has fixed priority, a losing cpu request waits in a one-deep slot */
`timescale 1ns/10ps
`default_nettype none

module vram_arbiter (
    input  wire                          i_clk,
    input  wire                          i_reset_n,
    input  wire  [vram_pkg::VDATA_W-1:0] i_video_data,
    vram_bus_if.arbiter                  fetch_bus,
    vram_bus_if.arbiter                  cpu_bus,
    output logic                         o_video_rd_n,
    output logic                         o_video_we_n,
    output logic [vram_pkg::VADDR_W-1:0] o_video_address,
    output logic [vram_pkg::VDATA_W-1:0] o_video_data
);

    logic                         pend_valid_r;
    logic                         pend_we_r;
    logic [vram_pkg::VADDR_W-1:0] pend_addr_r;
    logic [vram_pkg::VDATA_W-1:0] pend_wdata_r;

    logic                         owner_cpu_r;
    logic [vram_pkg::VADDR_W-1:0] addr_r;
    logic [vram_pkg::VDATA_W-1:0] data_r;

    logic                         issue;
    logic                         issue_cpu;
    logic                         issue_we;
    logic [vram_pkg::VADDR_W-1:0] issue_addr;
    logic [vram_pkg::VDATA_W-1:0] issue_wdata;
    logic                         park_cpu;

    // fetcher first, then the pending slot, then a fresh cpu request
    always_comb
    begin
        issue       = cpu_bus.req;
        issue_cpu   = 1'b1;
        issue_we    = cpu_bus.we;
        issue_addr  = cpu_bus.addr;
        issue_wdata = cpu_bus.wdata;
        if (fetch_bus.req)
        begin
            issue       = 1'b1;
            issue_cpu   = 1'b0;
            issue_we    = fetch_bus.we;
            issue_addr  = fetch_bus.addr;
            issue_wdata = fetch_bus.wdata;
        end
        else if (pend_valid_r)
        begin
            issue       = 1'b1;
            issue_we    = pend_we_r;
            issue_addr  = pend_addr_r;
            issue_wdata = pend_wdata_r;
        end
    end

    // cpu request that cannot go out this cycle
    assign park_cpu = cpu_bus.req && (fetch_bus.req || pend_valid_r);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pend_valid_r <= 1'b0;
        end
        else if (fetch_bus.req)
        begin
            pend_valid_r <= pend_valid_r || cpu_bus.req;
        end
        else
        begin
            pend_valid_r <= park_cpu;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (park_cpu)
        begin
            pend_we_r    <= cpu_bus.we;
            pend_addr_r  <= cpu_bus.addr;
            pend_wdata_r <= cpu_bus.wdata;
        end
    end

    // strobes are registered and fall back high after one cycle
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_video_rd_n <= 1'b1;
            o_video_we_n <= 1'b1;
            owner_cpu_r  <= 1'b0;
        end
        else
        begin
            o_video_rd_n <= !(issue && !issue_we);
            o_video_we_n <= !(issue && issue_we);
            owner_cpu_r  <= issue_cpu;
        end
    end

    always_ff @(posedge i_clk)
    begin
        addr_r <= issue_addr;
        data_r <= issue_wdata;
    end

    assign o_video_address = addr_r;
    assign o_video_data    = o_video_we_n ? '0 : data_r;

    // read data goes back during the strobe cycle to whoever owns it
    assign fetch_bus.rdata  = i_video_data;
    assign cpu_bus.rdata    = i_video_data;
    assign fetch_bus.rvalid = !o_video_rd_n && !owner_cpu_r;
    assign cpu_bus.rvalid   = !o_video_rd_n && owner_cpu_r;

endmodule

`default_nettype wire

// File: rtl/vram_bus_if.sv
/* one requester's port onto the shared video bus */
`timescale 1ns/10ps
`default_nettype none

interface vram_bus_if;

    logic                         req;
    logic                         we;
    logic [vram_pkg::VADDR_W-1:0] addr;
    logic [vram_pkg::VDATA_W-1:0] wdata;
    logic [vram_pkg::VDATA_W-1:0] rdata;
    logic                         rvalid;

    // req is a one-cycle strobe, rvalid answers a read for one cycle
    modport requester (
        output req, we, addr, wdata,
        input  rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, rvalid
    );

endinterface

`default_nettype wire

// File: rtl/vram_pkg.sv
/* video bus constants
   bus widths and the base addresses of the nametable and palette regions */
`default_nettype none

package vram_pkg;

    localparam int VADDR_W = 14;
    localparam int VDATA_W = 8;

    // palette region starts here, compared against the zero-extended vram address
    localparam logic [15:0] PALETTE_BASE = 16'h3F00;

    // first of the four nametables, 1 KB each
    localparam logic [VADDR_W-1:0] NAMETABLE_BASE = 14'h2000;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ppu_system.f \
    --top-module tb_ppu_system -o tb_ppu_system
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_ppu_system > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim/ppu_system_chk.sv
/* video bus and interrupt checker, bound into the PPU top level */
`timescale 1ns/10ps
`default_nettype none

module ppu_system_chk (
    input wire        i_clk,
    input wire        i_reset_n,
    input wire        i_cs_n,
    input wire        i_rw,
    input wire [2:0]  i_rs,
    input wire        o_int_n,
    input wire        o_video_rd_n,
    input wire        o_video_we_n,
    input wire [13:0] o_video_address
);

    logic status_rd;

    assign status_rd = !i_cs_n && (i_rw == ppu_pkg::RW_READ) &&
                       (i_rs == ppu_pkg::RS_PPUSTATUS);

    // read and write strobes never overlap
    strobe_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(!o_video_rd_n && !o_video_we_n))
        else $error("video read and write strobes low together");

    // one access per strobe cycle, back-to-back strobes carry a new address
    rd_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !o_video_rd_n |=> (o_video_rd_n || $changed(o_video_address)))
        else $error("read strobe held for a second cycle on one address");

    we_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !o_video_we_n |=> (o_video_we_n || $changed(o_video_address)))
        else $error("write strobe held for a second cycle on one address");

    int_release: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        status_rd |=> o_int_n)
        else $error("interrupt still low after a status read");

endmodule

`default_nettype wire

// File: sim/ppu_tests.txt
// columns: command _ argument a _ argument b
// 1 write reg a=data b, 2 read reg a expect b (bit 8 = no compare), 3 wait vblank irq
// 4 pixel x=a y=b, 5 vram addr a holds b, 6 int_n equals b, 7 wait visible line a
2_0002_0000
2_0004_0000
2_0007_0000
6_0000_0001
1_0003_0010
1_0004_00A5
1_0004_005C
1_0003_0010
2_0004_00A5
1_0003_0011
2_0004_005C
1_0006_0001
1_0006_0000
1_0007_0011
1_0007_0022
5_0100_0011
5_0101_0022
1_0006_0001
1_0006_0000
2_0007_0100
2_0007_0011
1_0006_0001
1_0006_0000
2_0007_0022
2_0007_0011
1_0000_0004
1_0006_0003
1_0006_0000
1_0007_00A1
1_0007_00A2
1_0000_0000
5_0300_00A1
5_0320_00A2
1_0006_003F
1_0006_0000
1_0007_000F
1_0007_0016
1_0007_002A
1_0007_0030
1_0006_003F
1_0006_0001
2_0007_0016
2_0007_002A
1_0000_0080
3_0000_0000
6_0000_0000
2_0002_0080
6_0000_0001
2_0002_0000
1_0006_0001
2_0002_0000
1_0006_0002
1_0006_0000
1_0007_0077
1_0000_0000
5_0200_0077
1_0000_0001
1_0001_0008
4_0010_0020
4_0085_0050
4_00F7_00E8
1_0001_0000
4_0040_0010
7_0064_0000
1_0006_0004
1_0006_0000
1_0007_00C1
1_0007_00C2
1_0007_00C3
1_0007_00C4
1_0007_00C5
1_0007_00C6
5_0400_00C1
5_0401_00C2
5_0402_00C3
5_0403_00C4
5_0404_00C5
5_0405_00C6

// File: sim/tb_ppu_system.sv
/* PPU system testbench
   runs the command list from ppu_tests.txt against a VRAM model and a register shadow */
`timescale 1ns/10ps
`default_nettype none

module tb_ppu_system;

    localparam int MAX_TESTS    = 128;
    localparam int FRAME_CYCLES = 341 * 262;

    logic        clk;
    logic        reset_n;
    logic        cs_n;
    logic        rw;
    logic [2:0]  rs;
    logic [7:0]  cpu_wdata;
    logic [7:0]  cpu_rdata;
    logic        int_n;
    logic        video_rd_n;
    logic        video_we_n;
    logic [13:0] video_address;
    logic [7:0]  video_wdata;
    logic [7:0]  video_rdata;
    logic [8:0]  video_x;
    logic [8:0]  video_y;
    logic        video_visible;
    logic [5:0]  video_colour;

    logic [7:0]  vram [0:16383];
    logic [35:0] tests [0:MAX_TESTS-1];

    // shadow of the register state the tests rely on
    logic [7:0]  sh_ctrl;
    logic [7:0]  sh_mask;
    logic        sh_toggle;
    logic [5:0]  sh_addr_hi;
    logic [13:0] sh_v;
    logic [7:0]  sh_pal [0:31];

    int          check_errors;
    int          wd_limit;
    logic        wd_armed;

    ppu_system dut_i (
        .i_clk           (clk),
        .i_reset_n       (reset_n),
        .i_cs_n          (cs_n),
        .i_rw            (rw),
        .i_rs            (rs),
        .i_data          (cpu_wdata),
        .o_data          (cpu_rdata),
        .o_int_n         (int_n),
        .o_video_rd_n    (video_rd_n),
        .o_video_we_n    (video_we_n),
        .o_video_address (video_address),
        .o_video_data    (video_wdata),
        .i_video_data    (video_rdata),
        .o_video_x       (video_x),
        .o_video_y       (video_y),
        .o_video_visible (video_visible),
        .o_video_colour  (video_colour)
    );

    bind ppu_system ppu_system_chk chk_i (.*);

    always #4 clk = !clk;

    // VRAM model answers within the strobe cycle
    assign video_rdata = vram[video_address];

    always @(posedge clk)
    begin
        if (!video_we_n)
        begin
            vram[video_address] <= video_wdata;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_value(input logic [7:0] got, input logic [7:0] exp,
                               input string what);
        assert (got == exp)
        else
        begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic shadow_access(input logic is_read, input logic [2:0] sel,
                                 input logic [7:0] d);
        logic [13:0] step;
        step = sh_ctrl[ppu_pkg::CTRL_INC32_BIT] ? 14'd32 : 14'd1;
        if (is_read)
        begin
            if (sel == ppu_pkg::RS_PPUSTATUS)
                sh_toggle = 1'b0;
            if (sel == ppu_pkg::RS_PPUDATA)
                sh_v = sh_v + step;
        end
        else
        begin
            case (sel)
                ppu_pkg::RS_PPUCTRL: sh_ctrl = d;
                ppu_pkg::RS_PPUMASK: sh_mask = d;
                ppu_pkg::RS_PPUSCROLL: sh_toggle = !sh_toggle;
                ppu_pkg::RS_PPUADDR:
                begin
                    if (!sh_toggle)
                        sh_addr_hi = d[5:0];
                    else
                        sh_v = {sh_addr_hi, d};
                    sh_toggle = !sh_toggle;
                end
                ppu_pkg::RS_PPUDATA:
                begin
                    if ({2'b00, sh_v} >= vram_pkg::PALETTE_BASE)
                        sh_pal[sh_v[4:0]] = d;
                    sh_v = sh_v + step;
                end
                default:
                begin
                end
            endcase
        end
    endtask

    // one cpu cycle, then idle long enough for a contested bus access
    task automatic cpu_access(input logic is_read, input logic [2:0] sel,
                              input logic [7:0] d, output logic [7:0] q);
        @(posedge clk);
        #1;
        cs_n      = 1'b0;
        rw        = is_read;
        rs        = sel;
        cpu_wdata = d;
        #4;
        q = cpu_rdata;
        @(posedge clk);
        #1;
        cs_n = 1'b1;
        rw   = ppu_pkg::RW_READ;
        shadow_access(is_read, sel, d);
        repeat (4) @(posedge clk);
    endtask

    task automatic check_pixel(input logic [8:0] x, input logic [8:0] y);
        logic [13:0] nt_addr;
        logic [7:0]  exp;
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!(video_visible && video_x == x && video_y == y));
        nt_addr = vram_pkg::NAMETABLE_BASE + 14'(sh_ctrl[1:0]) * 14'd1024 +
                  14'(y / 8) * 14'd32 + 14'(x / 8);
        if (sh_mask[ppu_pkg::MASK_BG_BIT])
            exp = sh_pal[vram[nt_addr][1:0]] & 8'h3F;
        else
            exp = sh_pal[0] & 8'h3F;
        check_value({2'b00, video_colour}, exp, $sformatf("pixel %0d,%0d", x, y));
    endtask

    initial
    begin
        logic [15:0] state;
        logic [7:0]  b;
        logic [3:0]  cmd;
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        logic [7:0]  q;
        int          n_tests;
        int          n_waits;
        int          n_failed;
        int          errs_before;

        clk          = 1'b0;
        reset_n      = 1'b0;
        cs_n         = 1'b1;
        rw           = ppu_pkg::RW_READ;
        rs           = 3'd0;
        cpu_wdata    = 8'h00;
        wd_armed     = 1'b0;
        wd_limit     = 0;
        check_errors = 0;
        n_failed     = 0;
        sh_ctrl      = 8'h00;
        sh_mask      = 8'h00;
        sh_toggle    = 1'b0;
        sh_addr_hi   = 6'd0;
        sh_v         = 14'd0;
        for (int i = 0; i < 32; i++)
            sh_pal[i] = 8'h00;

        // VRAM contents, eight LFSR steps per byte
        state = 16'd20678;
        for (int a = 0; a < 16384; a++)
        begin
            b = 8'h00;
            for (int k = 0; k < 8; k++)
            begin
                state = lfsr_next(state);
                b     = {b[6:0], state[0]};
            end
            vram[a] = b;
        end

        for (int i = 0; i < MAX_TESTS; i++)
            tests[i] = 36'hF_0000_0000;
        $readmemh("sim/ppu_tests.txt", tests);

        n_tests = 0;
        n_waits = 0;
        while (n_tests < MAX_TESTS && tests[n_tests][35:32] != 4'hF)
        begin
            cmd = tests[n_tests][35:32];
            if (cmd == 4'd3 || cmd == 4'd4 || cmd == 4'd7)
                n_waits++;
            n_tests++;
        end
        wd_limit = n_waits * 2 * FRAME_CYCLES + (n_tests - n_waits) * 1000 + 100;
        wd_armed = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int t = 0; t < n_tests; t++)
        begin
            cmd         = tests[t][35:32];
            arg_a       = tests[t][31:16];
            arg_b       = tests[t][15:0];
            errs_before = check_errors;
            case (cmd)
                4'd1: cpu_access(1'b0, arg_a[2:0], arg_b[7:0], q);
                4'd2:
                begin
                    cpu_access(1'b1, arg_a[2:0], 8'h00, q);
                    // bit 8 marks a priming read whose value is not compared
                    if (!arg_b[8])
                        check_value(q, arg_b[7:0], $sformatf("read of register %0d", arg_a));
                end
                4'd3:
                begin
                    do
                    begin
                        @(posedge clk);
                        #1;
                    end
                    while (int_n);
                end
                4'd4: check_pixel(arg_a[8:0], arg_b[8:0]);
                4'd5: check_value(vram[arg_a[13:0]], arg_b[7:0],
                                  $sformatf("vram at %04h", arg_a));
                4'd6:
                begin
                    @(posedge clk);
                    #1;
                    check_value({7'd0, int_n}, arg_b[7:0], "interrupt line");
                end
                4'd7:
                begin
                    do
                    begin
                        @(posedge clk);
                        #1;
                    end
                    while (!(video_visible && video_y == arg_a[8:0]));
                end
                default:
                begin
                    check_errors++;
                    $display("test %0d has unknown command %0h", t, cmd);
                end
            endcase
            if (check_errors != errs_before)
                n_failed++;
            $display("test %0d command %0h: %s", t, cmd,
                     (check_errors == errs_before) ? "ok" : "failed");
        end

        $display("tests run %0d, failed %0d, check errors %0d", n_tests, n_failed, check_errors);
        if (check_errors == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // ends a run that stops making progress
    initial
    begin
        wait (wd_armed);
        repeat (wd_limit) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", wd_limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
